// ==== dmc_cmd_pkg.sv ====
package dmc_cmd_pkg;

  // {cs_n, ras_n, cas_n, we_n}, all active low.
  typedef enum logic [3:0] {
    LMR      = 4'b0000,
    REF      = 4'b0001,
    PRE      = 4'b0010,
    ACT      = 4'b0011,
    WRITE    = 4'b0100,
    READ     = 4'b0101,
    NOP      = 4'b0111,
    DESELECT = 4'b1111
  } dfi_cmd_e;

  // Bit 0 selects read, bit 1 selects auto-precharge.
  typedef enum logic [2:0] {
    WR = 3'b000,
    RD = 3'b001,
    WP = 3'b010,
    RP = 3'b011
  } app_cmd_e;

  typedef enum logic [1:0] {IDLE, INIT, REFR, LDST} seq_state_e;

  typedef struct packed {
    dfi_cmd_e    cmd;
    logic [2:0]  bank;
    logic [15:0] addr;
  } cmd_entry_s;

endpackage

// ==== dmc_timing_pkg.sv ====
package dmc_timing_pkg;

  typedef logic [7:0] tick_t; // Saturates at all ones.

  localparam int dfi_addr_width_c = 16;
  localparam int dfi_bank_width_c = 3;

  localparam int dfi_burst_len_c = 4;

  // Timing defaults in DFI clock cycles.
  localparam int trefi_c       = 200;
  localparam int init_cycles_c = 16;
  localparam int tmrd_c        = 2;
  localparam int trfc_c        = 12;
  localparam int trp_c         = 3;
  localparam int tras_c        = 6;
  localparam int trrd_c        = 2;
  localparam int trcd_c        = 3;
  localparam int twr_c         = 3;
  localparam int twtr_c        = 4; // Keeps the write and read windows apart.
  localparam int trtp_c        = 2;
  localparam int trc_c         = 9;
  localparam int tcas_c        = 3;

  // Flat address map, bank field above row and column.
  localparam int bank_pos_c   = 24;
  localparam int bank_width_c = 3;
  localparam int row_width_c  = 14;
  localparam int col_width_c  = 10;

endpackage

// ==== dmc_bank_tracker.sv ====
`timescale 1ns/1ps

module dmc_bank_tracker #(
  parameter int app_addr_width_p,
  parameter int bank_pos_p,
  parameter int bank_width_p,
  parameter int row_width_p,
  parameter int col_width_p
) (
  input  logic                                         dfi_clk_i,
  input  logic                                         dfi_clk_sync_rst_i,
  input  logic [app_addr_width_p-1:0]                  app_addr_i,
  input  logic                                         push_i,
  input  dmc_cmd_pkg::cmd_entry_s                      entry_i,
  input  logic                                         auto_pre_i,
  output logic [dmc_timing_pkg::dfi_bank_width_c-1:0]  bank_o,
  output logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  row_o,
  output logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  col_o,
  output logic                                         bank_open_o,
  output logic                                         row_hit_o,
  output logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  open_row_o,
  output logic                                         any_open_o
);
  import dmc_cmd_pkg::*;

  localparam logic [app_addr_width_p-1:0] low_mask_lp  = app_addr_width_p'((1 << bank_pos_p) - 1);
  localparam logic [app_addr_width_p-1:0] bank_mask_lp = app_addr_width_p'((1 << bank_width_p) - 1);
  localparam logic [app_addr_width_p-1:0] row_mask_lp  = app_addr_width_p'((1 << row_width_p) - 1);
  localparam logic [app_addr_width_p-1:0] col_mask_lp  = app_addr_width_p'((1 << col_width_p) - 1);

  logic [app_addr_width_p-1:0] row_col;
  logic [7:0]                  open_bank;
  logic [15:0]                 open_row [8];

  // Squeeze the bank field out, leaving row above column.
  assign row_col = ((app_addr_i >> (bank_pos_p + bank_width_p)) << bank_pos_p)
                   | (app_addr_i & low_mask_lp);
  assign bank_o  = 3'((app_addr_i >> bank_pos_p) & bank_mask_lp);
  assign row_o   = 16'((row_col >> col_width_p) & row_mask_lp);
  assign col_o   = 16'(row_col & col_mask_lp);

  assign bank_open_o = open_bank[bank_o];
  assign open_row_o  = open_row[bank_o];
  assign row_hit_o   = bank_open_o && (open_row_o == row_o);
  assign any_open_o  = |open_bank;

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      open_bank <= '0;
    end else if (push_i) begin
      case (entry_i.cmd)
        ACT:         open_bank[entry_i.bank] <= 1'b1;
        WRITE, READ: if (auto_pre_i) open_bank[entry_i.bank] <= 1'b0;
        PRE: begin
          if (entry_i.addr[10]) open_bank <= '0; // Precharge all.
          else open_bank[entry_i.bank] <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (push_i && entry_i.cmd == ACT) open_row[entry_i.bank] <= entry_i.addr;
  end

endmodule

// ==== dmc_refresh_timer.sv ====
`timescale 1ns/1ps

module dmc_refresh_timer #(
  parameter int trefi_p
) (
  input  logic dfi_clk_i,
  input  logic dfi_clk_sync_rst_i,
  input  logic enable_i,
  input  logic refr_ack_i,
  output logic refr_req_o
);
  import dmc_timing_pkg::*;

  tick_t ref_tick;

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      ref_tick   <= '0;
      refr_req_o <= 1'b0;
    end else if (enable_i) begin
      if (ref_tick == tick_t'(trefi_p)) begin
        ref_tick   <= '0;
        refr_req_o <= 1'b1;
      end else if (refr_ack_i) begin
        refr_req_o <= 1'b0;
      end else if (!refr_req_o) begin
        ref_tick <= ref_tick + 1'b1; // Held while a refresh waits.
      end
    end
  end

endmodule

// ==== dmc_ctrl_fsm.sv ====
`timescale 1ns/1ps

module dmc_ctrl_fsm #(
  parameter int init_cycles_p,
  parameter int burst_len_p,
  parameter int tcas_p
) (
  input  logic                                         dfi_clk_i,
  input  logic                                         dfi_clk_sync_rst_i,
  input  logic                                         app_en_i,
  input  dmc_cmd_pkg::app_cmd_e                        app_cmd_i,
  input  logic                                         refr_req_i,
  input  logic                                         queue_ready_i,
  input  logic [dmc_timing_pkg::dfi_bank_width_c-1:0]  bank_i,
  input  logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  row_i,
  input  logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  col_i,
  input  logic                                         bank_open_i,
  input  logic                                         row_hit_i,
  input  logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  open_row_i,
  input  logic                                         any_open_i,
  output logic                                         app_rdy_o,
  output logic                                         push_o,
  output dmc_cmd_pkg::cmd_entry_s                      entry_o,
  output logic                                         auto_pre_o,
  output logic                                         refr_ack_o,
  output logic                                         init_calib_complete_o
);
  import dmc_cmd_pkg::*;

  seq_state_e  state, next_state;
  logic [15:0] step; // Entries left in the phase, the last one at zero.

  assign push_o     = (state != IDLE) && queue_ready_i;
  assign app_rdy_o  = (state == LDST) && push_o && (step == '0);
  assign refr_ack_o = (state == REFR) && push_o && (step == '0);
  assign auto_pre_o = app_cmd_i[1];

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (!init_calib_complete_o) next_state = INIT;
        else if (refr_req_i) next_state = REFR;
        else if (app_en_i) next_state = LDST;
      end
      default: if (push_o && step == '0) next_state = IDLE;
    endcase
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) state <= IDLE;
    else state <= next_state;
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      step <= '0;
    end else if (state == IDLE) begin
      case (next_state)
        INIT:    step <= 16'(init_cycles_p);
        REFR:    step <= {15'd0, any_open_i};
        LDST:    step <= row_hit_i ? 16'd0 : (bank_open_i ? 16'd2 : 16'd1);
        default: step <= '0;
      endcase
    end else if (push_o && step != '0) begin
      step <= step - 1'b1;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) init_calib_complete_o <= 1'b0;
    else if (state == INIT && push_o && step == '0) init_calib_complete_o <= 1'b1;
  end

  always_comb begin
    entry_o = '{cmd: DESELECT, bank: '0, addr: '0};
    case (state)
      INIT: begin
        case (step)
          16'd4:        entry_o = '{cmd: PRE, bank: '0, addr: 16'h0400};
          16'd3, 16'd2: entry_o.cmd = REF;
          16'd1: begin
            // CAS latency and burst length code.
            entry_o = '{cmd: LMR, bank: 3'd0,
                        addr: {8'h00, 4'(tcas_p), 4'($clog2(burst_len_p << 1))}};
          end
          16'd0:        entry_o = '{cmd: LMR, bank: 3'd2, addr: '0};
          default: ;    // Power-up wait.
        endcase
      end
      REFR: begin
        if (step[0]) entry_o = '{cmd: PRE, bank: '0, addr: 16'h0400};
        else entry_o.cmd = REF;
      end
      LDST: begin
        case (step[1:0])
          2'd2:    entry_o = '{cmd: PRE, bank: bank_i, addr: open_row_i};
          2'd1:    entry_o = '{cmd: ACT, bank: bank_i, addr: row_i};
          default: begin
            entry_o = '{cmd: app_cmd_i[0] ? READ : WRITE, bank: bank_i,
                        addr: {col_i[14:10], app_cmd_i[1], col_i[9:0]}}; // A10 is auto-precharge.
          end
        endcase
      end
      default: ;
    endcase
  end

endmodule

// ==== dmc_cmd_queue.sv ====
`timescale 1ns/1ps

module dmc_cmd_queue #(
  parameter int queue_depth_p
) (
  input  logic                    dfi_clk_i,
  input  logic                    dfi_clk_sync_rst_i,
  input  logic                    push_i,
  input  dmc_cmd_pkg::cmd_entry_s entry_i,
  input  logic                    pop_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output dmc_cmd_pkg::cmd_entry_s head_o
);
  import dmc_cmd_pkg::*;

  localparam int ptr_width_lp = $clog2(queue_depth_p);

  cmd_entry_s              mem [queue_depth_p];
  logic [ptr_width_lp-1:0] wr_ptr, rd_ptr;
  logic [ptr_width_lp:0]   count;
  logic                    do_push, do_pop;

  function automatic logic [ptr_width_lp-1:0] wrap_inc(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(queue_depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = count != (ptr_width_lp + 1)'(queue_depth_p);
  assign valid_o = count != '0;
  assign head_o  = mem[rd_ptr];
  assign do_push = push_i && ready_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge dfi_clk_i) begin
    if (do_push) mem[wr_ptr] <= entry_i;
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wrap_inc(wr_ptr);
      if (do_pop) rd_ptr <= wrap_inc(rd_ptr);
      count <= count + (ptr_width_lp + 1)'(do_push) - (ptr_width_lp + 1)'(do_pop);
    end
  end

endmodule

// ==== dmc_cmd_timer.sv ====
`timescale 1ns/1ps

module dmc_cmd_timer #(
  parameter int burst_len_p,
  parameter int tmrd_p,
  parameter int trfc_p,
  parameter int trp_p,
  parameter int tras_p,
  parameter int trrd_p,
  parameter int trcd_p,
  parameter int twr_p,
  parameter int twtr_p,
  parameter int trtp_p,
  parameter int trc_p,
  parameter int tcas_p
) (
  input  logic                  dfi_clk_i,
  input  logic                  dfi_clk_sync_rst_i,
  input  logic                  valid_i,
  input  dmc_cmd_pkg::dfi_cmd_e next_cmd_i,
  output logic                  issue_o
);
  import dmc_cmd_pkg::*;
  import dmc_timing_pkg::*;

  dfi_cmd_e last_cmd;
  tick_t    cmd_tick, act_tick, wr_tick, rd_tick;
  logic     ok;

  function automatic logic met(input tick_t t, input int n);
    return int'(t) >= n;
  endfunction

  function automatic tick_t sat_inc(input tick_t t);
    return (t == '1) ? t : t + 1'b1;
  endfunction

  always_comb begin
    ok = 1'b1;
    case (last_cmd)
      LMR: ok = met(cmd_tick, tmrd_p);
      REF: ok = met(cmd_tick, trfc_p);
      PRE: ok = met(cmd_tick, trp_p) && (next_cmd_i != ACT || met(act_tick, trc_p));
      ACT: begin
        case (next_cmd_i)
          PRE:     ok = met(cmd_tick, tras_p);
          ACT:     ok = met(cmd_tick, trrd_p);
          WRITE:   ok = met(cmd_tick, trcd_p) && met(rd_tick, tcas_p + burst_len_p - 1);
          READ:    ok = met(cmd_tick, trcd_p) && met(wr_tick, twtr_p);
          default: ;
        endcase
      end
      WRITE: begin
        case (next_cmd_i)
          PRE:     ok = met(cmd_tick, twr_p) && met(act_tick, tras_p);
          WRITE:   ok = met(cmd_tick, burst_len_p - 1);
          READ:    ok = met(cmd_tick, twtr_p);
          ACT:     ok = met(act_tick, trc_p) && met(cmd_tick, twr_p + trp_p); // Auto-precharge.
          default: ;
        endcase
      end
      READ: begin
        case (next_cmd_i)
          PRE:     ok = met(cmd_tick, trtp_p) && met(act_tick, tras_p);
          WRITE:   ok = met(cmd_tick, tcas_p + burst_len_p - 1);
          READ:    ok = met(cmd_tick, burst_len_p - 1);
          ACT:     ok = met(act_tick, trc_p) && met(cmd_tick, trtp_p + trp_p);
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  assign issue_o = valid_i && ok;

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      last_cmd <= NOP;
      cmd_tick <= '1; // Nothing issued yet.
      act_tick <= '1;
      wr_tick  <= '1;
      rd_tick  <= '1;
    end else begin
      if (issue_o) last_cmd <= next_cmd_i;
      cmd_tick <= issue_o ? '0 : sat_inc(cmd_tick);
      act_tick <= (issue_o && next_cmd_i == ACT) ? '0 : sat_inc(act_tick);
      wr_tick  <= (issue_o && next_cmd_i == WRITE) ? '0 : sat_inc(wr_tick);
      rd_tick  <= (issue_o && next_cmd_i == READ) ? '0 : sat_inc(rd_tick);
    end
  end

endmodule

// ==== dmc_dfi_issue.sv ====
`timescale 1ns/1ps

module dmc_dfi_issue #(
  parameter int burst_len_p,
  parameter int tcas_p
) (
  input  logic                                         dfi_clk_i,
  input  logic                                         dfi_clk_sync_rst_i,
  input  logic                                         issue_i,
  input  dmc_cmd_pkg::cmd_entry_s                      head_i,
  output logic                                         dfi_cke_o,
  output logic                                         dfi_cs_n_o,
  output logic                                         dfi_ras_n_o,
  output logic                                         dfi_cas_n_o,
  output logic                                         dfi_we_n_o,
  output logic [dmc_timing_pkg::dfi_bank_width_c-1:0]  dfi_bank_o,
  output logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  dfi_address_o,
  output logic                                         dfi_wrdata_en_o,
  output logic                                         dfi_rddata_en_o
);
  import dmc_cmd_pkg::*;
  import dmc_timing_pkg::*;

  logic [1:0] data_en; // Write window in bit 0, read in bit 1.

  assign dfi_wrdata_en_o = data_en[0];
  assign dfi_rddata_en_o = data_en[1];

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) dfi_cke_o <= 1'b0;
    else dfi_cke_o <= 1'b1;
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= DESELECT;
    end else if (issue_i) begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= head_i.cmd;
    end else begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= DESELECT;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (issue_i) begin
      dfi_bank_o    <= head_i.bank;
      dfi_address_o <= head_i.addr;
    end
  end

  // Write data starts one cycle earlier than read data.
  for (genvar ch = 0; ch < 2; ch++) begin : g_win
    localparam dfi_cmd_e match_lp = (ch == 0) ? WRITE : READ;
    localparam tick_t    delay_lp = tick_t'(tcas_p - 1 + ch);

    logic  cas_valid;
    tick_t cas_tick, burst_tick;

    always_ff @(posedge dfi_clk_i) begin
      if (dfi_clk_sync_rst_i) begin
        cas_valid <= 1'b0;
      end else if (issue_i && head_i.cmd == match_lp) begin
        cas_valid <= 1'b1;
        cas_tick  <= delay_lp;
      end else if (cas_valid) begin
        cas_tick <= cas_tick - 1'b1;
        if (cas_tick == 8'd1) cas_valid <= 1'b0;
      end
    end

    always_ff @(posedge dfi_clk_i) begin
      if (dfi_clk_sync_rst_i) begin
        data_en[ch] <= 1'b0;
      end else if (cas_valid && cas_tick == 8'd1) begin
        data_en[ch] <= 1'b1;
        burst_tick  <= tick_t'(burst_len_p - 1);
      end else if (data_en[ch]) begin
        burst_tick <= burst_tick - 1'b1;
        if (burst_tick == '0) data_en[ch] <= 1'b0;
      end
    end
  end

endmodule

// ==== dmc_top.sv ====
`timescale 1ns/1ps

module dmc_top #(
  parameter int app_addr_width_p = 28,
  parameter int bank_pos_p       = dmc_timing_pkg::bank_pos_c,
  parameter int bank_width_p     = dmc_timing_pkg::bank_width_c,
  parameter int row_width_p      = dmc_timing_pkg::row_width_c,
  parameter int col_width_p      = dmc_timing_pkg::col_width_c,
  parameter int burst_len_p      = dmc_timing_pkg::dfi_burst_len_c,
  parameter int trefi_p          = dmc_timing_pkg::trefi_c,
  parameter int init_cycles_p    = dmc_timing_pkg::init_cycles_c,
  parameter int tmrd_p           = dmc_timing_pkg::tmrd_c,
  parameter int trfc_p           = dmc_timing_pkg::trfc_c,
  parameter int trp_p            = dmc_timing_pkg::trp_c,
  parameter int tras_p           = dmc_timing_pkg::tras_c,
  parameter int trrd_p           = dmc_timing_pkg::trrd_c,
  parameter int trcd_p           = dmc_timing_pkg::trcd_c,
  parameter int twr_p            = dmc_timing_pkg::twr_c,
  parameter int twtr_p           = dmc_timing_pkg::twtr_c,
  parameter int trtp_p           = dmc_timing_pkg::trtp_c,
  parameter int trc_p            = dmc_timing_pkg::trc_c,
  parameter int tcas_p           = dmc_timing_pkg::tcas_c,
  parameter int queue_depth_p    = 4
) (
  input  logic                                         dfi_clk_i,
  input  logic                                         dfi_clk_sync_rst_i,
  input  logic                                         app_en_i,
  input  dmc_cmd_pkg::app_cmd_e                        app_cmd_i,
  input  logic [app_addr_width_p-1:0]                  app_addr_i,
  output logic                                         app_rdy_o,
  output logic                                         init_calib_complete_o,
  output logic                                         dfi_cke_o,
  output logic                                         dfi_cs_n_o,
  output logic                                         dfi_ras_n_o,
  output logic                                         dfi_cas_n_o,
  output logic                                         dfi_we_n_o,
  output logic [dmc_timing_pkg::dfi_bank_width_c-1:0]  dfi_bank_o,
  output logic [dmc_timing_pkg::dfi_addr_width_c-1:0]  dfi_address_o,
  output logic                                         dfi_wrdata_en_o,
  output logic                                         dfi_rddata_en_o
);
  import dmc_cmd_pkg::*;
  import dmc_timing_pkg::*;

  logic                        push, auto_pre, queue_ready, queue_valid, issue;
  logic                        refr_req, refr_ack;
  cmd_entry_s                  entry, head;
  logic [dfi_bank_width_c-1:0] bank;
  logic [dfi_addr_width_c-1:0] row, col, open_row;
  logic                        bank_open, row_hit, any_open;

  dmc_bank_tracker #(
    .app_addr_width_p(app_addr_width_p), .bank_pos_p(bank_pos_p),
    .bank_width_p(bank_width_p), .row_width_p(row_width_p), .col_width_p(col_width_p)
  ) u_tracker (
    .dfi_clk_i, .dfi_clk_sync_rst_i, .app_addr_i,
    .push_i(push), .entry_i(entry), .auto_pre_i(auto_pre),
    .bank_o(bank), .row_o(row), .col_o(col), .bank_open_o(bank_open),
    .row_hit_o(row_hit), .open_row_o(open_row), .any_open_o(any_open)
  );

  dmc_refresh_timer #(.trefi_p(trefi_p)) u_refresh (
    .dfi_clk_i, .dfi_clk_sync_rst_i, .enable_i(init_calib_complete_o),
    .refr_ack_i(refr_ack), .refr_req_o(refr_req)
  );

  dmc_ctrl_fsm #(
    .init_cycles_p(init_cycles_p), .burst_len_p(burst_len_p), .tcas_p(tcas_p)
  ) u_fsm (
    .dfi_clk_i, .dfi_clk_sync_rst_i, .app_en_i, .app_cmd_i,
    .refr_req_i(refr_req), .queue_ready_i(queue_ready),
    .bank_i(bank), .row_i(row), .col_i(col), .bank_open_i(bank_open),
    .row_hit_i(row_hit), .open_row_i(open_row), .any_open_i(any_open),
    .app_rdy_o, .push_o(push), .entry_o(entry), .auto_pre_o(auto_pre),
    .refr_ack_o(refr_ack), .init_calib_complete_o
  );

  dmc_cmd_queue #(.queue_depth_p(queue_depth_p)) u_queue (
    .dfi_clk_i, .dfi_clk_sync_rst_i, .push_i(push), .entry_i(entry), .pop_i(issue),
    .ready_o(queue_ready), .valid_o(queue_valid), .head_o(head)
  );

  dmc_cmd_timer #(
    .burst_len_p(burst_len_p), .tmrd_p(tmrd_p), .trfc_p(trfc_p), .trp_p(trp_p),
    .tras_p(tras_p), .trrd_p(trrd_p), .trcd_p(trcd_p), .twr_p(twr_p),
    .twtr_p(twtr_p), .trtp_p(trtp_p), .trc_p(trc_p), .tcas_p(tcas_p)
  ) u_timer (
    .dfi_clk_i, .dfi_clk_sync_rst_i, .valid_i(queue_valid), .next_cmd_i(head.cmd),
    .issue_o(issue)
  );

  dmc_dfi_issue #(.burst_len_p(burst_len_p), .tcas_p(tcas_p)) u_issue (
    .dfi_clk_i, .dfi_clk_sync_rst_i, .issue_i(issue), .head_i(head),
    .dfi_cke_o, .dfi_cs_n_o, .dfi_ras_n_o, .dfi_cas_n_o, .dfi_we_n_o,
    .dfi_bank_o, .dfi_address_o, .dfi_wrdata_en_o, .dfi_rddata_en_o
  );

endmodule

// ==== dmc_sva.sv ====
`timescale 1ns/1ps

module dmc_sva (
  input logic dfi_clk_i,
  input logic dfi_clk_sync_rst_i,
  input logic dfi_cs_n_o,
  input logic dfi_wrdata_en_o,
  input logic dfi_rddata_en_o
);

  a_en_excl: assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    !(dfi_wrdata_en_o && dfi_rddata_en_o))
    else $error("Write and read data enables high together.");

  // Each issued command holds chip select low for one bus cycle.
  a_cs_one_cycle: assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    !dfi_cs_n_o |=> dfi_cs_n_o)
    else $error("Chip select low in two consecutive cycles.");

endmodule

// ==== tb_dmc_top.sv ====
`timescale 1ns/1ps

module tb_dmc_top;
  import dmc_cmd_pkg::*;

  localparam int burst_len_lp   = 4;
  localparam int init_cycles_lp = 16;
  localparam int trefi_lp       = 200;
  localparam int tmrd_lp        = 2;
  localparam int trfc_lp        = 12;
  localparam int trp_lp         = 3;
  localparam int trrd_lp        = 2;
  localparam int trcd_lp        = 3;
  localparam int tcas_lp        = 3;
  localparam int max_vec_lp     = 32;
  localparam int seq_cost_lp    = 40; // Worst row miss plus data window.

  logic        clk, rst, app_en, app_rdy, init_done;
  app_cmd_e    app_cmd;
  logic [27:0] app_addr;
  logic        cke, cs_n, ras_n, cas_n, we_n, wr_en, rd_en;
  logic [2:0]  dfi_bank;
  logic [15:0] dfi_addr;

  string       v_name [max_vec_lp];
  logic [31:0] v_kind [max_vec_lp];
  logic [31:0] v_cmd [max_vec_lp];
  logic [31:0] v_addr [max_vec_lp];
  int          v_n [max_vec_lp];
  logic [31:0] v_ec [max_vec_lp][5];
  logic [31:0] v_eb [max_vec_lp][5];
  logic [31:0] v_ea [max_vec_lp][5];
  int          n_vec, cyc, limit, last_cyc, last_wr, last_rd;
  logic        fail_seen, run_done, have_last, wr_seen, rd_seen;
  logic [3:0]  last_cmd, now_cmd;
  logic [3:0]  mon_cmd [$];
  logic [2:0]  mon_bank [$];
  logic [15:0] mon_addr [$];

  dmc_top #(
    .burst_len_p(burst_len_lp), .init_cycles_p(init_cycles_lp), .trefi_p(trefi_lp),
    .tmrd_p(tmrd_lp), .trfc_p(trfc_lp), .trp_p(trp_lp), .trrd_p(trrd_lp),
    .trcd_p(trcd_lp), .tcas_p(tcas_lp)
  ) uut (
    .dfi_clk_i(clk), .dfi_clk_sync_rst_i(rst), .app_en_i(app_en), .app_cmd_i(app_cmd),
    .app_addr_i(app_addr), .app_rdy_o(app_rdy), .init_calib_complete_o(init_done),
    .dfi_cke_o(cke), .dfi_cs_n_o(cs_n), .dfi_ras_n_o(ras_n), .dfi_cas_n_o(cas_n),
    .dfi_we_n_o(we_n), .dfi_bank_o(dfi_bank), .dfi_address_o(dfi_addr),
    .dfi_wrdata_en_o(wr_en), .dfi_rddata_en_o(rd_en)
  );

  bind dmc_dfi_issue dmc_sva u_sva (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_fail();
    fail_seen = 1'b1;
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      report_fail();
    end
  endtask

  // Minimum bus cycles between two commands.
  function automatic int min_gap(input logic [3:0] prev, input logic [3:0] next);
    if (prev == LMR) return tmrd_lp;
    if (prev == REF) return trfc_lp;
    if (prev == PRE && next == ACT) return trp_lp;
    if (prev == ACT && next == ACT) return trrd_lp;
    if (prev == ACT && (next == WRITE || next == READ)) return trcd_lp;
    if (prev == next && (next == WRITE || next == READ)) return burst_len_lp - 1;
    return 1;
  endfunction

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("dmc_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file dmc_vectors.txt.");
      report_fail();
    end
    n_vec = 0;
    while ($fgets(line, fd)) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line,
        "%s %h %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        v_name[n_vec], v_kind[n_vec], v_cmd[n_vec], v_addr[n_vec], v_n[n_vec],
        v_ec[n_vec][0], v_eb[n_vec][0], v_ea[n_vec][0],
        v_ec[n_vec][1], v_eb[n_vec][1], v_ea[n_vec][1],
        v_ec[n_vec][2], v_eb[n_vec][2], v_ea[n_vec][2],
        v_ec[n_vec][3], v_eb[n_vec][3], v_ea[n_vec][3],
        v_ec[n_vec][4], v_eb[n_vec][4], v_ea[n_vec][4]);
      if (cnt != 20) begin
        $display("Malformed line in the vector file: %s", line);
        report_fail();
      end
      n_vec++;
    end
    $fclose(fd);
  endtask

  task automatic run_vector(input int i);
    if (v_kind[i] == 0) begin
      app_cmd  = app_cmd_e'(v_cmd[i][2:0]);
      app_addr = v_addr[i][27:0];
      app_en   = 1'b1;
      do @(negedge clk); while (!app_rdy);
      @(negedge clk);
      app_en = 1'b0; // Accepted on the last rising edge.
    end
    while (mon_cmd.size() < v_n[i]) @(negedge clk);
    for (int k = 0; k < v_n[i]; k++) begin
      check({v_name[i], " cmd"}, v_ec[i][k], 32'(mon_cmd.pop_front()));
      check({v_name[i], " bank"}, v_eb[i][k], 32'(mon_bank.pop_front()));
      check({v_name[i], " address"}, v_ea[i][k], 32'(mon_addr.pop_front()));
    end
    check({v_name[i], " init_calib_complete"}, 1, init_done);
  endtask

  // Bus monitor, gap rules and data-enable windows.
  always @(negedge clk) begin
    if (!rst) begin
      cyc++;
      if (cyc > limit) begin
        $display("Timeout: expected DFI commands did not appear within %0d cycles.", limit);
        report_fail();
      end
      if (!cs_n) begin
        now_cmd = {cs_n, ras_n, cas_n, we_n};
        if (have_last) check("command gap", 1, (cyc - last_cyc) >= min_gap(last_cmd, now_cmd));
        mon_cmd.push_back(now_cmd);
        mon_bank.push_back(dfi_bank);
        mon_addr.push_back(dfi_addr);
        have_last = 1'b1;
        last_cmd  = now_cmd;
        last_cyc  = cyc;
        if (now_cmd == WRITE) begin
          wr_seen = 1'b1;
          last_wr = cyc;
        end
        if (now_cmd == READ) begin
          rd_seen = 1'b1;
          last_rd = cyc;
        end
      end
      check("wrdata_en", wr_seen && cyc >= last_wr + tcas_lp - 1
            && cyc < last_wr + tcas_lp - 1 + burst_len_lp, wr_en);
      check("rddata_en", rd_seen && cyc >= last_rd + tcas_lp
            && cyc < last_rd + tcas_lp + burst_len_lp, rd_en);
    end
  end

  final begin
    if (!run_done && !fail_seen) $display("STATUS: FAIL");
  end

  initial begin
    rst       = 1'b1;
    app_en    = 1'b0;
    app_cmd   = WR;
    app_addr  = '0;
    cyc       = 0;
    fail_seen = 1'b0;
    run_done  = 1'b0;
    have_last = 1'b0;
    wr_seen   = 1'b0;
    rd_seen   = 1'b0;
    load_vectors();
    limit = n_vec * seq_cost_lp + init_cycles_lp + trefi_lp;
    repeat (4) @(negedge clk);
    check("reset cs_n", 1, cs_n);
    check("reset cke", 0, cke);
    check("reset wrdata_en", 0, wr_en);
    check("reset rddata_en", 0, rd_en);
    check("reset init_calib_complete", 0, init_done);
    check("reset app_rdy", 0, app_rdy);
    rst = 1'b0;
    @(negedge clk);
    check("cke after reset", 1, cke);
    for (int i = 0; i < n_vec; i++) run_vector(i);
    run_done = 1'b1;
    if (fail_seen) begin
      $display("STATUS: FAIL");
      $fatal(1, "Checks failed.");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== files.f ====
dmc_cmd_pkg.sv
dmc_timing_pkg.sv
dmc_bank_tracker.sv
dmc_refresh_timer.sv
dmc_ctrl_fsm.sv
dmc_cmd_queue.sv
dmc_cmd_timer.sv
dmc_dfi_issue.sv
dmc_top.sv
dmc_sva.sv
tb_dmc_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dmc_top
RTL_TOP   ?= dmc_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dmc_vectors.txt ====
# name kind app_cmd app_addr n, then five (dfi_cmd bank address) triples; hex except n.
# kind 1 waits without a request; dfi_cmd is {cs_n,ras_n,cas_n,we_n}; unused triples are 0.
init      1 0 0000000 5 2 0 0400 1 0 0000 1 0 0000 0 0 0033 0 2 0000
wr_closed 0 0 1001410 2 3 1 0005 4 1 0010 0 0 0000 0 0 0000 0 0 0000
rd_hit    0 1 1001420 1 5 1 0020 0 0 0000 0 0 0000 0 0 0000 0 0 0000
wr_miss   0 0 1001c30 3 2 1 0005 3 1 0007 4 1 0030 0 0 0000 0 0 0000
rp_hit    0 3 1001c40 1 5 1 0440 0 0 0000 0 0 0000 0 0 0000 0 0 0000
rd_closed 0 1 1001c08 2 3 1 0007 5 1 0008 0 0 0000 0 0 0000 0 0 0000
wp_other  0 2 2000c04 2 3 2 0003 4 2 0404 0 0 0000 0 0 0000 0 0 0000
refresh   1 0 0000000 2 2 0 0400 1 0 0000 0 0 0000 0 0 0000 0 0 0000
